// File: Bender.yml
package:
  name: catch_game

sources:
  - rtl/catch_pkg.sv
  - rtl/step_timer.sv
  - rtl/falling_object.sv
  - rtl/catcher_ctrl.sv
  - rtl/score_counter.sv
  - rtl/matrix_scan.sv
  - rtl/score_display.sv
  - rtl/catch_game_top.sv
  - target: simulation
    files:
      - sim/catch_checker.sv
      - sim/tb_catch_game.sv

// File: rtl/catch_game_top.sv
`timescale 1ns/1ps

module catch_game_top import catch_pkg::*; #(
	parameter int SCAN_DIV = catch_pkg::SCAN_DIV,
	parameter int STEP_DIV = catch_pkg::STEP_DIV
) (
	input  logic CLK,
	input  logic clear,
	input  logic left,
	input  logic right,
	output pixels_t data_r,
	output pixels_t data_g,
	output pixels_t data_b,
	output col_t scan_col,
	output seg_t seg,
	output logic [1:0] digit_sel
);

	logic scan_tick;
	logic step_tick;
	col_t catcher_pos;
	col_t col_1;
	col_t col_2;
	col_t col_3;
	row_t row_1;
	row_t row_2;
	row_t row_3;
	logic vis_1;
	logic vis_2;
	logic vis_3;
	logic caught_1;
	logic caught_2;
	logic caught_3;
	bcd_t score_tens;
	bcd_t score_units;

	step_timer #(.SCAN_DIV(SCAN_DIV), .STEP_DIV(STEP_DIV)) timer0 (
		.CLK(CLK), .clear(clear), .scan_tick(scan_tick), .step_tick(step_tick)
	);

	////////////////////
	// red, green, blue objects
	falling_object #(.POINTS(KIND1_POINTS), .GAP(KIND1_GAP), .LCG_OFFSET(KIND1_OFFSET)) obj1 (
		.CLK(CLK), .clear(clear), .step_tick(step_tick), .catcher_pos(catcher_pos),
		.column(col_1), .row(row_1), .visible(vis_1), .caught(caught_1)
	);

	falling_object #(.POINTS(KIND2_POINTS), .GAP(KIND2_GAP), .LCG_OFFSET(KIND2_OFFSET)) obj2 (
		.CLK(CLK), .clear(clear), .step_tick(step_tick), .catcher_pos(catcher_pos),
		.column(col_2), .row(row_2), .visible(vis_2), .caught(caught_2)
	);

	falling_object #(.POINTS(KIND3_POINTS), .GAP(KIND3_GAP), .LCG_OFFSET(KIND3_OFFSET)) obj3 (
		.CLK(CLK), .clear(clear), .step_tick(step_tick), .catcher_pos(catcher_pos),
		.column(col_3), .row(row_3), .visible(vis_3), .caught(caught_3)
	);

	catcher_ctrl catcher0 (
		.CLK(CLK), .clear(clear), .step_tick(step_tick), .left(left), .right(right),
		.catcher_pos(catcher_pos)
	);

	score_counter #(.POINTS_1(KIND1_POINTS), .POINTS_2(KIND2_POINTS), .POINTS_3(KIND3_POINTS))
	score0 (
		.CLK(CLK), .clear(clear), .caught_1(caught_1), .caught_2(caught_2),
		.caught_3(caught_3), .score_tens(score_tens), .score_units(score_units)
	);

	////////////////////
	// outputs
	matrix_scan mscan0 (
		.CLK(CLK), .clear(clear), .scan_tick(scan_tick), .catcher_pos(catcher_pos),
		.col_1(col_1), .col_2(col_2), .col_3(col_3),
		.row_1(row_1), .row_2(row_2), .row_3(row_3),
		.vis_1(vis_1), .vis_2(vis_2), .vis_3(vis_3),
		.data_r(data_r), .data_g(data_g), .data_b(data_b), .scan_col(scan_col)
	);

	score_display disp0 (
		.CLK(CLK), .clear(clear), .scan_tick(scan_tick), .score_tens(score_tens),
		.score_units(score_units), .seg(seg), .digit_sel(digit_sel)
	);

endmodule

// File: rtl/catch_pkg.sv
package catch_pkg;

	////////////////////
	// widths
	typedef logic [2:0] col_t;
	typedef logic [2:0] row_t;      // row 0 at the top
	typedef logic [7:0] pixels_t;   // active low, bit = row
	typedef logic [3:0] bcd_t;
	typedef logic [6:0] seg_t;      // a..g, active low
	typedef logic [3:0] lcg_t;
	typedef logic [2:0] points_t;   // 0 to 6 per step

	// object life cycle
	typedef enum logic [1:0]
	{
		PH_START,
		PH_FALL,
		PH_GAP
	} phase_t;

	////////////////////
	// game constants
	localparam int MATRIX_SIZE = 8;
	localparam col_t CATCHER_START = 3'd3;
	localparam col_t CATCHER_MAX = 3'd6;  // catcher spans pos and pos+1
	localparam int SCAN_DIV = 5000;
	localparam int STEP_DIV = 4000000;
	localparam int LCG_MUL = 5;
	localparam int LCG_ADD = 3;

	// object kinds, red green blue
	localparam int KIND1_POINTS = 1;
	localparam int KIND1_GAP = 0;
	localparam int KIND1_OFFSET = 0;
	localparam int KIND2_POINTS = 2;
	localparam int KIND2_GAP = 2;
	localparam int KIND2_OFFSET = 1;
	localparam int KIND3_POINTS = 3;
	localparam int KIND3_GAP = 3;
	localparam int KIND3_OFFSET = 2;

endpackage

// File: rtl/catcher_ctrl.sv
`timescale 1ns/1ps

module catcher_ctrl import catch_pkg::*; (
	input  logic CLK,
	input  logic clear,
	input  logic step_tick,
	input  logic left,
	input  logic right,
	output col_t catcher_pos
);

	logic move_r;
	logic move_l;

	// clamps block each move on its own
	assign move_r = right && (catcher_pos != CATCHER_MAX);
	assign move_l = left && (catcher_pos != '0);

	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
			catcher_pos <= CATCHER_START;
		else if (step_tick)
		begin
			if (move_r && !move_l)
				catcher_pos <= catcher_pos + 1'b1;
			else if (move_l && !move_r)
				catcher_pos <= catcher_pos - 1'b1;
		end
	end

endmodule

// File: rtl/falling_object.sv
`timescale 1ns/1ps

module falling_object import catch_pkg::*; #(
	parameter int POINTS = 1,
	parameter int GAP = 0,
	parameter int LCG_OFFSET = 0
) (
	input  logic CLK,
	input  logic clear,
	input  logic step_tick,
	input  col_t catcher_pos,
	output col_t column,
	output row_t row,
	output logic visible,
	output logic caught
);

	localparam int GW = (GAP > 0) ? $clog2(GAP + 1) : 1;
	localparam row_t LAST_ROW = row_t'(MATRIX_SIZE - 1);

	phase_t phase;
	lcg_t lcg;
	lcg_t lcg_next;
	logic [GW-1:0] gap_cnt;
	logic at_bottom;
	logic over_catcher;

	assign lcg_next = lcg_t'(LCG_MUL * (int'(lcg) + LCG_OFFSET) + LCG_ADD);

	assign visible = (phase == PH_FALL);
	assign at_bottom = visible && (row == LAST_ROW);
	assign over_catcher = (column == catcher_pos) || (column == col_t'(catcher_pos + 1'b1));
	assign caught = step_tick && at_bottom && over_catcher;

	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			phase <= PH_START;
			lcg <= '0;
			column <= '0;
			row <= '0;
			gap_cnt <= '0;
		end
		else if (step_tick)
		begin
			case (phase)
				PH_START:
				begin
					phase <= PH_FALL;  // first drop uses the cleared state
					column <= lcg[2:0];
					row <= '0;
				end
				PH_FALL:
				begin
					if (row == LAST_ROW)  // caught or missed, same exit
					begin
						phase <= PH_GAP;
						gap_cnt <= GW'(GAP);
					end
					else
						row <= row + 1'b1;
				end
				PH_GAP:
				begin
					if (gap_cnt == '0)
					begin
						lcg <= lcg_next;
						column <= lcg_next[2:0];
						row <= '0;
						phase <= PH_FALL;
					end
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default:
					phase <= PH_START;
			endcase
		end
	end

endmodule

// File: rtl/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan import catch_pkg::*; (
	input  logic CLK,
	input  logic clear,
	input  logic scan_tick,
	input  col_t catcher_pos,
	input  col_t col_1,
	input  col_t col_2,
	input  col_t col_3,
	input  row_t row_1,
	input  row_t row_2,
	input  row_t row_3,
	input  logic vis_1,
	input  logic vis_2,
	input  logic vis_3,
	output pixels_t data_r,
	output pixels_t data_g,
	output pixels_t data_b,
	output col_t scan_col
);

	col_t next_col;
	logic catcher_here;

	// one object's pixel in column c
	function automatic pixels_t obj_pixels(col_t c, col_t oc, row_t r, logic v);
		pixels_t p;
		p = '1;
		if (v && (oc == c))
			p[r] = 1'b0;
		return p;
	endfunction

	assign next_col = (scan_col == col_t'(MATRIX_SIZE - 1)) ? '0 : scan_col + 1'b1;
	assign catcher_here = (next_col == catcher_pos)
		|| (next_col == col_t'(catcher_pos + 1'b1));

	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			scan_col <= '0;
			data_r <= '1;
			data_g <= '1;
			data_b <= '1;
		end
		else if (scan_tick)
		begin
			scan_col <= next_col;
			// catcher is white on the bottom row
			data_r <= obj_pixels(next_col, col_1, row_1, vis_1) & {~catcher_here, 7'h7f};
			data_g <= obj_pixels(next_col, col_2, row_2, vis_2) & {~catcher_here, 7'h7f};
			data_b <= obj_pixels(next_col, col_3, row_3, vis_3) & {~catcher_here, 7'h7f};
		end
	end

endmodule

// File: rtl/score_counter.sv
`timescale 1ns/1ps

module score_counter import catch_pkg::*; #(
	parameter int POINTS_1 = 1,
	parameter int POINTS_2 = 2,
	parameter int POINTS_3 = 3
) (
	input  logic CLK,
	input  logic clear,
	input  logic caught_1,
	input  logic caught_2,
	input  logic caught_3,
	output bcd_t score_tens,
	output bcd_t score_units
);

	points_t caught_sum;
	points_t step_points;  // sum held for one clock
	logic [4:0] units_sum;
	logic carry;
	bcd_t units_next;
	bcd_t tens_next;

	assign caught_sum = points_t'((caught_1 ? POINTS_1 : 0) + (caught_2 ? POINTS_2 : 0)
		+ (caught_3 ? POINTS_3 : 0));

	always_comb
	begin
		units_sum = {1'b0, score_units} + step_points;  // at most 15
		carry = (units_sum >= 5'd10);
		units_next = carry ? bcd_t'(units_sum - 5'd10) : units_sum[3:0];
		if (!carry)
			tens_next = score_tens;
		else if (score_tens == 4'd9)
			tens_next = '0;  // wrap past 99
		else
			tens_next = score_tens + 1'b1;
	end

	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			step_points <= '0;
			score_tens <= '0;
			score_units <= '0;
		end
		else
		begin
			step_points <= caught_sum;
			score_units <= units_next;
			score_tens <= tens_next;
		end
	end

endmodule

// File: rtl/score_display.sv
`timescale 1ns/1ps

module score_display import catch_pkg::*; (
	input  logic CLK,
	input  logic clear,
	input  logic scan_tick,
	input  bcd_t score_tens,
	input  bcd_t score_units,
	output seg_t seg,
	output logic [1:0] digit_sel
);

	logic show_tens;
	bcd_t digit;

	////////////////////
	// bcd to segments, bit 0 = a
	function automatic seg_t seg_decode(bcd_t d);
		seg_t s;
		case (d)
			4'd0: s = 7'b1000000;
			4'd1: s = 7'b1111001;
			4'd2: s = 7'b0100100;
			4'd3: s = 7'b0110000;
			4'd4: s = 7'b0011001;
			4'd5: s = 7'b0010010;
			4'd6: s = 7'b0000010;
			4'd7: s = 7'b1111000;
			4'd8: s = 7'b0000000;
			4'd9: s = 7'b0010000;
			default: s = 7'b1111111;  // blank
		endcase
		return s;
	endfunction

	////////////////////
	// digit multiplexing
	assign show_tens = (digit_sel == 2'b10);  // units now, tens next
	assign digit = show_tens ? score_tens : score_units;

	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			seg <= '1;
			digit_sel <= 2'b11;  // both commons off
		end
		else if (scan_tick)
		begin
			seg <= seg_decode(digit);
			digit_sel <= show_tens ? 2'b01 : 2'b10;
		end
	end

endmodule

// File: rtl/step_timer.sv
`timescale 1ns/1ps

module step_timer import catch_pkg::*; #(
	parameter int SCAN_DIV = catch_pkg::SCAN_DIV,
	parameter int STEP_DIV = catch_pkg::STEP_DIV
) (
	input  logic CLK,
	input  logic clear,
	output logic scan_tick,
	output logic step_tick
);

	localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int STEP_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

	logic [SCAN_W-1:0] scan_cnt;
	logic [STEP_W-1:0] step_cnt;

	// display refresh rate
	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			scan_cnt <= '0;
			scan_tick <= 1'b0;
		end
		else if (scan_cnt == SCAN_W'(SCAN_DIV - 1))
		begin
			scan_cnt <= '0;
			scan_tick <= 1'b1;
		end
		else
		begin
			scan_cnt <= scan_cnt + 1'b1;
			scan_tick <= 1'b0;
		end
	end

	// game speed
	always_ff @(posedge CLK or posedge clear)
	begin
		if (clear)
		begin
			step_cnt <= '0;
			step_tick <= 1'b0;
		end
		else if (step_cnt == STEP_W'(STEP_DIV - 1))
		begin
			step_cnt <= '0;
			step_tick <= 1'b1;
		end
		else
		begin
			step_cnt <= step_cnt + 1'b1;
			step_tick <= 1'b0;
		end
	end

endmodule

// File: sim/catch_checker.sv
`timescale 1ns/1ps

module catch_checker import catch_pkg::*; #(
	parameter int STEP_CYCLES = 64
) (
	input  logic CLK,
	input  logic clear,
	input  logic left,
	input  logic right,
	input  pixels_t data_r,
	input  pixels_t data_g,
	input  pixels_t data_b,
	input  col_t scan_col,
	input  seg_t seg,
	input  logic [1:0] digit_sel,
	input  col_t dut_pos,
	input  col_t exp_pos,
	input  logic pos_check,
	output int error_count,
	output int frame_count,
	output logic wrap_seen
);

	int k_points [3];
	int k_gap [3];
	int k_off [3];

	// model, index 0 red, 1 green, 2 blue
	bit m_vis [3];
	bit m_started [3];
	int m_col [3];
	int m_row [3];
	int m_wait [3];
	int m_lcg [3];
	int m_pos;
	int m_score;

	int step_cnt;
	bit step_now;
	int scans_seen;
	col_t last_col;
	pixels_t got_r [8];
	pixels_t got_g [8];
	pixels_t got_b [8];
	seg_t got_units;
	seg_t got_tens;

	initial
	begin
		k_points[0] = KIND1_POINTS;
		k_points[1] = KIND2_POINTS;
		k_points[2] = KIND3_POINTS;
		k_gap[0] = KIND1_GAP;
		k_gap[1] = KIND2_GAP;
		k_gap[2] = KIND3_GAP;
		k_off[0] = KIND1_OFFSET;
		k_off[1] = KIND2_OFFSET;
		k_off[2] = KIND3_OFFSET;
		error_count = 0;
		frame_count = 0;
	end

	////////////////////
	// expected patterns
	function automatic seg_t seg_pattern(int d);
		case (d)  // bit 0 = a, low = lit
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0010000;
		endcase
	endfunction

	function automatic pixels_t model_pixels(int k, int c);
		pixels_t p;
		p = '1;
		if (m_vis[k] && (m_col[k] == c))
			p[m_row[k]] = 1'b0;
		if ((c == m_pos) || (c == m_pos + 1))
			p[7] = 1'b0;  // catcher row
		return p;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		error_count++;
		$display("CHECK FAILED %s: got %0h expected %0h at %0t", name, got, expected, $time);
	endtask

	////////////////////
	// game model
	task automatic reset_model();
		int k;
		for (k = 0; k < 3; k++)
		begin
			m_vis[k] = 0;
			m_started[k] = 0;
			m_col[k] = 0;
			m_row[k] = 0;
			m_wait[k] = 0;
			m_lcg[k] = 0;
		end
		m_pos = CATCHER_START;
		m_score = 0;
		step_cnt = 0;
		step_now = 0;
		scans_seen = 1;  // no stale column after clear
		last_col = '0;
		wrap_seen = 1'b0;
		got_units = 'x;
		got_tens = 'x;
	endtask

	task automatic advance_model();
		int k;
		int gained;
		bit go_r;
		bit go_l;
		gained = 0;
		for (k = 0; k < 3; k++)
		begin
			if (m_vis[k])
			begin
				if (m_row[k] == 7)
				begin
					if ((m_col[k] == m_pos) || (m_col[k] == m_pos + 1))
						gained += k_points[k];
					m_vis[k] = 0;
					m_wait[k] = k_gap[k];
				end
				else
					m_row[k]++;
			end
			else if (!m_started[k])
			begin
				m_started[k] = 1;  // first drop at column 0
				m_vis[k] = 1;
				m_col[k] = 0;
				m_row[k] = 0;
			end
			else if (m_wait[k] == 0)
			begin
				m_lcg[k] = (LCG_MUL * (m_lcg[k] + k_off[k]) + LCG_ADD) % 16;
				m_col[k] = m_lcg[k] % 8;
				m_row[k] = 0;
				m_vis[k] = 1;
			end
			else
				m_wait[k]--;
		end
		go_r = right && (m_pos != CATCHER_MAX);
		go_l = left && (m_pos != 0);
		if (go_r && !go_l)
			m_pos++;
		else if (go_l && !go_r)
			m_pos--;
		if (m_score + gained >= 100)
			wrap_seen = 1'b1;
		m_score = (m_score + gained) % 100;
		scans_seen = 0;
		got_units = 'x;
		got_tens = 'x;
	endtask

	task automatic compare_frame();
		int c;
		for (c = 0; c < MATRIX_SIZE; c++)
		begin
			if (got_r[c] !== model_pixels(0, c))
				report_mismatch($sformatf("data_r col %0d", c), got_r[c], model_pixels(0, c));
			if (got_g[c] !== model_pixels(1, c))
				report_mismatch($sformatf("data_g col %0d", c), got_g[c], model_pixels(1, c));
			if (got_b[c] !== model_pixels(2, c))
				report_mismatch($sformatf("data_b col %0d", c), got_b[c], model_pixels(2, c));
		end
		if (got_units !== seg_pattern(m_score % 10))
			report_mismatch("seg units", got_units, seg_pattern(m_score % 10));
		if (got_tens !== seg_pattern(m_score / 10))
			report_mismatch("seg tens", got_tens, seg_pattern(m_score / 10));
		frame_count++;
	endtask

	////////////////////
	// outputs are read before this edge updates them
	always @(posedge CLK or posedge clear)
	begin
		if (clear)
			reset_model();
		else
		begin
			if (step_now)
				advance_model();
			step_now = (step_cnt == STEP_CYCLES - 1);
			step_cnt = (step_cnt == STEP_CYCLES - 1) ? 0 : step_cnt + 1;

			if (pos_check && (dut_pos !== exp_pos))
				report_mismatch("catcher_pos", dut_pos, exp_pos);

			if (scan_col !== last_col)
			begin
				if (scan_col !== col_t'(last_col + 1'b1))
					report_mismatch("scan_col", scan_col, col_t'(last_col + 1'b1));
				last_col = scan_col;
				scans_seen++;
				// first column after a step still shows the old state
				if ((scans_seen >= 2) && (scans_seen <= 9))
				begin
					got_r[scan_col] = data_r;
					got_g[scan_col] = data_g;
					got_b[scan_col] = data_b;
					if (digit_sel == 2'b10)
						got_units = seg;
					else if (digit_sel == 2'b01)
						got_tens = seg;
				end
				if (scans_seen == 9)
					compare_frame();
			end
		end
	end

endmodule

// File: sim/tb_catch_game.sv
`timescale 1ns/1ps

module tb_catch_game import catch_pkg::*; ();

	localparam int SIM_SCAN_DIV = 4;
	localparam int SIM_STEP_DIV = 64;
	localparam int RANDOM_ENTRIES = 16;

	logic CLK;
	logic clear;
	logic left;
	logic right;
	pixels_t data_r;
	pixels_t data_g;
	pixels_t data_b;
	col_t scan_col;
	seg_t seg;
	logic [1:0] digit_sel;
	col_t dut_pos;
	col_t exp_pos;
	logic pos_check;
	int error_count;
	int frame_count;
	logic wrap_seen;

	// stimulus table, one row per entry
	logic tab_left [$];
	logic tab_right [$];
	col_t tab_pos [$];
	int tab_reps [$];

	int cycles = 0;
	int cycle_limit;
	int tb_errors;

	catch_game_top #(.SCAN_DIV(SIM_SCAN_DIV), .STEP_DIV(SIM_STEP_DIV)) dut0 (
		.CLK(CLK), .clear(clear), .left(left), .right(right),
		.data_r(data_r), .data_g(data_g), .data_b(data_b), .scan_col(scan_col),
		.seg(seg), .digit_sel(digit_sel)
	);

	assign dut_pos = dut0.catcher_pos;

	catch_checker #(.STEP_CYCLES(SIM_STEP_DIV)) check0 (
		.CLK(CLK), .clear(clear), .left(left), .right(right),
		.data_r(data_r), .data_g(data_g), .data_b(data_b), .scan_col(scan_col),
		.seg(seg), .digit_sel(digit_sel), .dut_pos(dut_pos), .exp_pos(exp_pos),
		.pos_check(pos_check), .error_count(error_count), .frame_count(frame_count),
		.wrap_seen(wrap_seen)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic col_t next_catcher_pos(col_t pos, logic l, logic r);
		logic go_r;
		logic go_l;
		go_r = r && (pos != CATCHER_MAX);
		go_l = l && (pos != 3'd0);
		if (go_r && !go_l)
			return pos + 1'b1;
		if (go_l && !go_r)
			return pos - 1'b1;
		return pos;
	endfunction

	task automatic add_entry(input logic l, input logic r, input col_t pos, input int reps);
		tab_left.push_back(l);
		tab_right.push_back(r);
		tab_pos.push_back(pos);
		tab_reps.push_back(reps);
	endtask

	// the edge where the DUT acts on its step strobe
	task automatic wait_for_step();
		do
			@(posedge CLK);
		while (!dut0.step_tick);
	endtask

	initial
	begin
		int i;
		int k;
		int reps;
		int total_steps;
		int frames_before;
		logic l;
		logic r;
		col_t pos;
		CLK = 1'b0;
		clear = 1'b1;
		left = 1'b0;
		right = 1'b0;
		exp_pos = CATCHER_START;
		pos_check = 1'b0;
		tb_errors = 0;
		void'($urandom(86));

		////////////////////
		// left, right, position after, steps
		add_entry(1'b0, 1'b0, 3'd3, 1);
		add_entry(1'b1, 1'b0, 3'd2, 1);
		add_entry(1'b1, 1'b0, 3'd1, 1);
		add_entry(1'b1, 1'b0, 3'd0, 1);
		add_entry(1'b1, 1'b0, 3'd0, 2);  // left clamp
		add_entry(1'b0, 1'b1, 3'd1, 1);
		add_entry(1'b1, 1'b0, 3'd0, 1);  // all three land on column 0 next
		add_entry(1'b1, 1'b1, 3'd1, 1);  // left blocked at 0
		add_entry(1'b1, 1'b1, 3'd1, 2);
		add_entry(1'b0, 1'b1, 3'd6, 5);
		add_entry(1'b0, 1'b1, 3'd6, 2);  // right clamp
		add_entry(1'b1, 1'b1, 3'd5, 1);
		add_entry(1'b0, 1'b0, 3'd5, 1);
		pos = 3'd5;
		for (i = 0; i < RANDOM_ENTRIES; i++)
		begin
			l = 1'($urandom % 2);
			r = 1'($urandom % 2);
			reps = 1 + ($urandom % 3);
			for (k = 0; k < reps; k++)
				pos = next_catcher_pos(pos, l, r);
			add_entry(l, r, pos, reps);
		end
		// green always falls in column 0, long enough to pass 99
		add_entry(1'b1, 1'b0, 3'd0, 450);

		total_steps = 0;
		for (i = 0; i < tab_reps.size(); i++)
			total_steps += tab_reps[i];
		cycle_limit = (total_steps + 4) * SIM_STEP_DIV + 500;

		repeat (2) @(posedge CLK);
		clear <= 1'b0;

		for (i = 0; i < tab_reps.size(); i++)
		begin
			@(posedge CLK);
			left <= tab_left[i];
			right <= tab_right[i];
			for (k = 0; k < tab_reps[i]; k++)
				wait_for_step();
			@(posedge CLK);
			exp_pos <= tab_pos[i];
			pos_check <= 1'b1;
			@(posedge CLK);
			pos_check <= 1'b0;
		end

		frames_before = frame_count;
		while (frame_count <= frames_before)
			@(posedge CLK);
		if (!wrap_seen)
		begin
			$display("the score never wrapped past 99");
			tb_errors++;
		end

		$display("errors: checker %0d, testbench %0d", error_count, tb_errors);
		if (error_count + tb_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog.f
rtl/catch_pkg.sv
rtl/step_timer.sv
rtl/falling_object.sv
rtl/catcher_ctrl.sv
rtl/score_counter.sv
rtl/matrix_scan.sv
rtl/score_display.sv
rtl/catch_game_top.sv
sim/catch_checker.sv
sim/tb_catch_game.sv
